// File: source/bldc_pkg.sv
`default_nettype none

package bldc_pkg;

    typedef enum logic [1:0] {
        mode_run       = 2'd0,
        mode_calibrate = 2'd1,
        mode_test      = 2'd2
    } drive_mode_t; // code 3 falls back to run.

    localparam int table_len      = 64;
    localparam int quarter_turn   = table_len / 4;
    localparam int phase_v_shift  = table_len / 3;
    localparam int phase_w_shift  = table_len / 3 * 2;
    localparam int feedback_shift = 4; // feedback / 16.
    localparam int magnitude_max  = 100;
    localparam int pwm_prescale   = 4;
    localparam int pwm_period     = 256;

    typedef logic [5:0] table_idx_t;
    typedef logic [7:0] sine_t;
    typedef logic [7:0] magnitude_t;
    typedef logic [7:0] duty_t;

    // one electrical period, centred on 127.
    localparam sine_t sine_table [0:table_len-1] = '{
        8'd127, 8'd139, 8'd151, 8'd163, 8'd175, 8'd186, 8'd197, 8'd207,
        8'd216, 8'd225, 8'd232, 8'd239, 8'd244, 8'd248, 8'd251, 8'd253,
        8'd254, 8'd253, 8'd251, 8'd248, 8'd244, 8'd239, 8'd232, 8'd225,
        8'd216, 8'd207, 8'd197, 8'd186, 8'd175, 8'd163, 8'd151, 8'd139,
        8'd127, 8'd114, 8'd102, 8'd90,  8'd78,  8'd67,  8'd56,  8'd46,
        8'd37,  8'd28,  8'd21,  8'd14,  8'd9,   8'd5,   8'd2,   8'd0,
        8'd0,   8'd0,   8'd2,   8'd5,   8'd9,   8'd14,  8'd21,  8'd28,
        8'd37,  8'd46,  8'd56,  8'd67,  8'd78,  8'd90,  8'd102, 8'd114
    };

endpackage

`default_nettype wire

// File: source/commutation_if.sv
`timescale 1ns/1ps
`default_nettype none

interface commutation_if;

    bldc_pkg::table_idx_t idx_u;
    bldc_pkg::table_idx_t idx_v;
    bldc_pkg::table_idx_t idx_w;
    bldc_pkg::magnitude_t magnitude; // percent, 0 to 100.

    modport source (output idx_u, idx_v, idx_w, magnitude);
    modport sink (input idx_u, idx_v, idx_w, magnitude);

endinterface

`default_nettype wire

// File: source/duty_if.sv
`timescale 1ns/1ps
`default_nettype none

interface duty_if;

    bldc_pkg::duty_t duty_u;
    bldc_pkg::duty_t duty_v;
    bldc_pkg::duty_t duty_w;
    logic            update; // end of a three-phase round.

    modport source (output duty_u, duty_v, duty_w, update);
    modport sink (input duty_u, duty_v, duty_w, update);

endinterface

`default_nettype wire

// File: source/rotor_phase.sv
`timescale 1ns/1ps
`default_nettype none

module rotor_phase (
    input  logic                  clk,
    input  logic                  rst_n,
    input  bldc_pkg::drive_mode_t mode,
    input  logic signed [15:0]    velocity,
    input  logic signed [7:0]     offset,
    input  logic [15:0]           feedback,
    commutation_if.source         cmt
);

    bldc_pkg::table_idx_t base;
    bldc_pkg::table_idx_t offs;
    bldc_pkg::table_idx_t lead;
    bldc_pkg::table_idx_t idx_u;
    logic [15:0]          vel_abs;

    assign base = bldc_pkg::table_idx_t'(feedback >> bldc_pkg::feedback_shift);
    assign offs = bldc_pkg::table_idx_t'(offset); // modulo 64.

    // reverse direction leads by a quarter turn, forward lags.
    assign lead = velocity[15] ? bldc_pkg::table_idx_t'(bldc_pkg::quarter_turn)
                               : bldc_pkg::table_idx_t'(bldc_pkg::table_len -
                                                        bldc_pkg::quarter_turn);

    always_comb begin
        case (mode)
            bldc_pkg::mode_test:      idx_u = offs;
            bldc_pkg::mode_calibrate: idx_u = base + offs;
            default:                  idx_u = base + offs + lead;
        endcase
    end

    assign vel_abs = velocity[15] ? 16'(-velocity) : 16'(velocity);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmt.idx_u     <= '0;
            cmt.idx_v     <= '0;
            cmt.idx_w     <= '0;
            cmt.magnitude <= '0;
        end else begin
            cmt.idx_u <= idx_u;
            cmt.idx_v <= idx_u + bldc_pkg::table_idx_t'(bldc_pkg::phase_v_shift);
            cmt.idx_w <= idx_u + bldc_pkg::table_idx_t'(bldc_pkg::phase_w_shift);
            if (vel_abs > 16'(bldc_pkg::magnitude_max)) begin
                cmt.magnitude <= bldc_pkg::magnitude_t'(bldc_pkg::magnitude_max);
            end else begin
                cmt.magnitude <= bldc_pkg::magnitude_t'(vel_abs);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/shift_add_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module shift_add_multiplier (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load,
    input  logic [7:0]  a,
    input  logic [7:0]  b,
    output logic        valid,
    output logic [15:0] product
);

    logic [15:0] pp [8];
    logic [15:0] pp_sum;
    logic        load_d;

    // stage 1: one shifted copy of b per set bit of a.
    always_ff @(posedge clk) begin
        if (load) begin
            for (int i = 0; i < 8; i++) begin
                pp[i] <= a[i] ? ({8'b0, b} << i) : 16'b0;
            end
        end
    end

    always_comb begin
        pp_sum = '0;
        for (int i = 0; i < 8; i++) begin
            pp_sum = pp_sum + pp[i];
        end
    end

    // stage 2: sum, valid lines up with it.
    always_ff @(posedge clk) begin
        if (load_d) begin
            product <= pp_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_d <= 1'b0;
            valid  <= 1'b0;
        end else begin
            load_d <= load;
            valid  <= load_d;
        end
    end

endmodule

`default_nettype wire

// File: source/duty_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module duty_sequencer (
    input  logic        clk,
    input  logic        rst_n,
    commutation_if.sink cmt,
    duty_if.source      duty
);

    logic [1:0]           phase; // phase in flight, 0 = u.
    logic [1:0]           next_phase;
    logic                 busy;
    logic                 issue;
    bldc_pkg::table_idx_t next_idx;
    logic                 load;
    logic [7:0]           op_a;
    logic [7:0]           op_b;
    logic                 valid;
    logic [15:0]          product;
    bldc_pkg::duty_t      scaled;

    shift_add_multiplier i_mult (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .a       (op_a),
        .b       (op_b),
        .valid   (valid),
        .product (product)
    );

    // next load goes out in the same cycle the previous product lands.
    assign issue      = !busy || valid;
    assign next_phase = !busy ? phase : (phase == 2'd2 ? 2'd0 : phase + 2'd1);
    assign scaled     = bldc_pkg::duty_t'(product / 16'(bldc_pkg::magnitude_max));

    always_comb begin
        case (next_phase)
            2'd0:    next_idx = cmt.idx_u;
            2'd1:    next_idx = cmt.idx_v;
            default: next_idx = cmt.idx_w;
        endcase
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            op_a <= bldc_pkg::sine_table[next_idx];
            op_b <= cmt.magnitude;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase       <= 2'd0;
            busy        <= 1'b0;
            load        <= 1'b0;
            duty.duty_u <= '0;
            duty.duty_v <= '0;
            duty.duty_w <= '0;
            duty.update <= 1'b0;
        end else begin
            load        <= issue;
            duty.update <= 1'b0;
            if (issue) begin
                phase <= next_phase;
                busy  <= 1'b1;
            end
            if (busy && valid) begin
                case (phase)
                    2'd0: duty.duty_u <= scaled;
                    2'd1: duty.duty_v <= scaled;
                    default: begin
                        duty.duty_w <= scaled;
                        duty.update <= 1'b1; // round complete.
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: source/pwm_bank.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_bank (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   enable,
    duty_if.sink   duty,
    output logic   en,
    output logic   u,
    output logic   v,
    output logic   w
);

    localparam int presc_w = $clog2(bldc_pkg::pwm_prescale);
    localparam int count_w = $clog2(bldc_pkg::pwm_period);

    logic [presc_w-1:0] presc;
    logic               tick;
    logic [count_w-1:0] count;
    logic               wrap;
    bldc_pkg::duty_t    duty_u_q;
    bldc_pkg::duty_t    duty_v_q;
    bldc_pkg::duty_t    duty_w_q;

    assign tick = (presc == presc_w'(bldc_pkg::pwm_prescale - 1));
    assign wrap = tick && (count == count_w'(bldc_pkg::pwm_period - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc    <= '0;
            count    <= '0;
            duty_u_q <= '0;
            duty_v_q <= '0;
            duty_w_q <= '0;
            en       <= 1'b0;
        end else begin
            en    <= enable;
            presc <= tick ? '0 : presc + 1'b1;
            if (tick) begin
                count <= count + 1'b1; // wraps at 256.
            end
            if (wrap) begin
                duty_u_q <= duty.duty_u; // new duty only at period start.
                duty_v_q <= duty.duty_v;
                duty_w_q <= duty.duty_w;
            end
        end
    end

    // high for the first duty ticks of the period.
    assign u = en && (count < duty_u_q);
    assign v = en && (count < duty_v_q);
    assign w = en && (count < duty_w_q);

endmodule

`default_nettype wire

// File: source/bldc_drive.sv
`timescale 1ns/1ps
`default_nettype none

module bldc_drive (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  bldc_pkg::drive_mode_t mode,
    input  logic signed [15:0]    velocity,
    input  logic signed [7:0]     offset,
    input  logic [15:0]           feedback,
    output logic                  en,
    output logic                  u,
    output logic                  v,
    output logic                  w
);

    commutation_if cmt ();
    duty_if        duty ();

    rotor_phase i_rotor_phase (
        .clk      (clk),
        .rst_n    (rst_n),
        .mode     (mode),
        .velocity (velocity),
        .offset   (offset),
        .feedback (feedback),
        .cmt      (cmt.source)
    );

    duty_sequencer i_duty_sequencer (
        .clk   (clk),
        .rst_n (rst_n),
        .cmt   (cmt.sink),
        .duty  (duty.source)
    );

    pwm_bank i_pwm_bank (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .duty   (duty.sink),
        .en     (en),
        .u      (u),
        .v      (v),
        .w      (w)
    );

endmodule

`default_nettype wire

// File: sim/bldc_drive_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module bldc_drive_asserts (
    input logic            clk,
    input logic            rst_n,
    input logic            enable,
    input logic            en,
    input logic            u,
    input logic            v,
    input logic            w,
    input bldc_pkg::duty_t duty_u,
    input bldc_pkg::duty_t duty_v,
    input bldc_pkg::duty_t duty_w,
    input logic            update
);

    assert property (@(posedge clk) disable iff (!rst_n) !en |-> !(u || v || w))
        else $error("phase output high while en is low");

    assert property (@(posedge clk) disable iff (!rst_n) $past(rst_n) |-> en == $past(enable))
        else $error("en does not follow enable by one cycle");

    // sine peak is 254, so no duty can go above it.
    assert property (@(posedge clk) disable iff (!rst_n)
                     duty_u <= 8'd254 && duty_v <= 8'd254 && duty_w <= 8'd254)
        else $error("duty above the sine table peak");

    // end of round is a single-cycle strobe.
    assert property (@(posedge clk) disable iff (!rst_n) update |=> !update)
        else $error("duty update strobe held for more than one cycle");

endmodule

bind bldc_drive bldc_drive_asserts i_asserts (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (enable),
    .en     (en),
    .u      (u),
    .v      (v),
    .w      (w),
    .duty_u (duty.duty_u),
    .duty_v (duty.duty_v),
    .duty_w (duty.duty_w),
    .update (duty.update)
);

`default_nettype wire

// File: sim/bldc_drive_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bldc_drive_tb;

    localparam int period_clks = bldc_pkg::pwm_prescale * bldc_pkg::pwm_period;

    logic                  clk;
    logic                  rst_n;
    logic                  enable;
    bldc_pkg::drive_mode_t mode;
    logic signed [15:0]    velocity;
    logic signed [7:0]     offset;
    logic [15:0]           feedback;
    logic                  en, u, v, w;

    bldc_drive i_dut (.*);

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_duty(string test, string phase, bldc_pkg::duty_t exp,
                              bldc_pkg::duty_t act);
        if (act !== exp) begin
            $display("** Error %s, phase %s: expected %0d, actual %0d", test, phase, exp, act);
            abort_run();
        end
    endtask

    task automatic check_level(string test, string name, logic exp, logic act);
        if (act !== exp) begin
            $display("** Error %s, %s: expected %b, actual %b", test, name, exp, act);
            abort_run();
        end
    endtask

    // index rule, then sine times magnitude over 100.
    function automatic bldc_pkg::duty_t expected_duty(bldc_pkg::drive_mode_t m, int vel,
                                                      int offs, int fb, int shift);
        int idx;
        int mag;
        idx = offs + shift;
        if (m != bldc_pkg::mode_test) begin
            idx += fb / 16;
        end
        if (m == bldc_pkg::mode_run) begin
            idx += (vel < 0) ? bldc_pkg::quarter_turn : -bldc_pkg::quarter_turn;
        end
        idx = ((idx % bldc_pkg::table_len) + bldc_pkg::table_len) % bldc_pkg::table_len;
        mag = (vel < 0) ? -vel : vel;
        if (mag > bldc_pkg::magnitude_max) begin
            mag = bldc_pkg::magnitude_max;
        end
        return bldc_pkg::duty_t'(int'(bldc_pkg::sine_table[idx]) * mag / 100);
    endfunction

    task automatic drive_command(bldc_pkg::drive_mode_t m, int vel, int offs, int fb);
        @(negedge clk);
        mode     = m;
        velocity = 16'(vel);
        offset   = 8'(offs);
        feedback = 16'(fb);
    endtask

    // any phase rising marks a wrap.
    task automatic wait_period_start();
        logic prev;
        logic cur;
        prev = u | v | w;
        for (int n = 0; n < 3 * period_clks; n++) begin
            @(negedge clk);
            cur = u | v | w;
            if (cur && !prev) begin
                return;
            end
            prev = cur;
        end
        $display("timeout: no phase output rose to mark the start of a PWM period");
        abort_run();
    endtask

    task automatic measure_period(output int hu, output int hv, output int hw);
        hu = 0;
        hv = 0;
        hw = 0;
        for (int k = 0; k < bldc_pkg::pwm_period; k++) begin
            if (k > 0) begin
                repeat (bldc_pkg::pwm_prescale) @(negedge clk);
            end
            hu += int'(u);
            hv += int'(v);
            hw += int'(w);
        end
    endtask

    task automatic check_case(string test, bldc_pkg::drive_mode_t m, int vel, int offs, int fb);
        int hu;
        int hv;
        int hw;
        drive_command(m, vel, offs, fb);
        wait_period_start();
        wait_period_start(); // first full period with the new duties.
        measure_period(hu, hv, hw);
        check_duty(test, "u", expected_duty(m, vel, offs, fb, 0), bldc_pkg::duty_t'(hu));
        check_duty(test, "v", expected_duty(m, vel, offs, fb, bldc_pkg::phase_v_shift),
                   bldc_pkg::duty_t'(hv));
        check_duty(test, "w", expected_duty(m, vel, offs, fb, bldc_pkg::phase_w_shift),
                   bldc_pkg::duty_t'(hw));
    endtask

    task automatic gating_after_reset();
        check_level("reset", "en", 1'b0, en);
        check_level("reset", "u|v|w", 1'b0, u | v | w);
        drive_command(bldc_pkg::mode_test, 100, 0, 0);
        repeat (2 * period_clks) begin
            @(negedge clk);
            check_level("gating", "u|v|w", 1'b0, u | v | w);
        end
        enable = 1'b1;
        check_level("enable", "en", 1'b0, en);
        @(negedge clk);
        check_level("enable", "en", 1'b1, en);
    endtask

    task automatic calibrate_random();
        int fb;
        int offs;
        for (int i = 0; i < 8; i++) begin
            fb   = int'($urandom % 65536);
            offs = int'($urandom % 256) - 128;
            check_case("calibrate", bldc_pkg::mode_calibrate, 60, offs, fb);
        end
    endtask

    task automatic magnitude_limits();
        check_case("saturation", bldc_pkg::mode_run, 3000, 3, 16'h1230);
        check_case("saturation", bldc_pkg::mode_run, 100, 3, 16'h1230);
        drive_command(bldc_pkg::mode_run, 0, 3, 16'h1230);
        repeat (2 * period_clks) @(negedge clk);
        repeat (period_clks) begin
            @(negedge clk);
            check_level("zero", "en", 1'b1, en);
            check_level("zero", "u|v|w", 1'b0, u | v | w);
        end
    endtask

    initial begin
        void'($urandom(32'h770353c1));
        clk      = 1'b0;
        rst_n    = 1'b0;
        enable   = 1'b0;
        mode     = bldc_pkg::mode_test;
        velocity = '0;
        offset   = '0;
        feedback = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        gating_after_reset();
        // feedback is ignored in test mode.
        check_case("test_mode", bldc_pkg::mode_test, 100, 0, 16'h1230);
        check_case("test_mode", bldc_pkg::mode_test, 100, 10, 16'h1230);
        check_case("test_mode", bldc_pkg::mode_test, 100, -5, 16'h1230);
        calibrate_random();
        check_case("run_forward", bldc_pkg::mode_run, 80, 0, 16'h1230);
        check_case("run_reverse", bldc_pkg::mode_run, -80, 0, 16'h1230);
        magnitude_limits();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bldc_drive.f
source/bldc_pkg.sv
source/commutation_if.sv
source/duty_if.sv
source/rotor_phase.sv
source/shift_add_multiplier.sv
source/duty_sequencer.sv
source/pwm_bank.sv
source/bldc_drive.sv
sim/bldc_drive_asserts.sv
sim/bldc_drive_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = bldc_drive_tb
FILELIST = bldc_drive.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
